/* testbench/l1d_testdata.txt */
# op size(0 b,1 h,2 w,4 bu,5 hu) addr wdata expected_rdata expected_mem_reads(dec)
# initial word at byte address a is (a>>2) xor 5a5a0000; hex fields except the last
R 2 00000100 00000000 5a5a0040 4
R 2 00000100 00000000 5a5a0040 0
R 2 0000010c 00000000 5a5a0043 0
W 0 00000101 000000a5 00000000 0
W 1 00000106 0000ffee 00000000 0
W 2 00000108 87654321 00000000 0
R 0 00000101 00000000 ffffffa5 0
R 4 00000101 00000000 000000a5 0
R 0 00000100 00000000 00000040 0
R 1 00000106 00000000 ffffffee 0
R 5 00000106 00000000 0000ffee 0
R 1 0000010a 00000000 ffff8765 0
R 4 0000010b 00000000 00000087 0
R 2 00000500 00000000 5a5a0140 4
R 2 00000104 00000000 ffee0041 4
R 2 00000100 00000000 5a5aa540 0
W 2 00000204 cafef00d 00000000 0
W 0 00000203 00000077 00000000 0
R 2 00000204 00000000 cafef00d 4
R 2 00000200 00000000 775a0080 0
R 1 00000203 00000000 00000000 0
R 2 0000020e 00000000 00000000 0

/* all.f */
hw/cache_geom_pkg.sv
hw/mem_access_pkg.sv
hw/l1d_ctrl.sv
hw/tag_valid_store.sv
hw/line_data_store.sv
hw/load_align.sv
hw/l1d_cache.sv
testbench/mem_model.sv
testbench/tb_l1d_cache.sv

/* Makefile */
# Verilator build and run for the L1 data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_l1d_cache
FILELIST  ?= all.f
BUILD_DIR ?= build
SIM_BIN   ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/$(SIM_BIN)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN) -f $(FILELIST)

# run from the project root so the test data path resolves
run: compile
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_l1d_cache.sv */
/* replays the access list twice, first without memory wait states, then after a fresh
   reset of cache and memory with random ones. test addresses must stay below 4 KiB. */
module tb_l1d_cache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    timeout_cycles = 100;  // a refill with waits needs about 20
  localparam string data_path      = "testbench/l1d_testdata.txt";

  // one line of the access list
  typedef struct packed {
    logic [7:0]  op;        // R or W
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [31:0] exp_reads;
  } test_entry_t;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       rand_waits;
  mem_access_pkg::core_req_t  core_req;
  mem_access_pkg::core_resp_t core_resp;
  mem_access_pkg::mem_req_t   mem_req;
  mem_access_pkg::mem_resp_t  mem_resp;
  int unsigned                read_count;
  int unsigned                write_count;
  int unsigned                reads_at_start;  // memory reads before the current access
  logic [31:0]                line_base;       // line of the current access
  test_entry_t                cur_test;        // access in progress
  string                      cur_name;        // its name in error lines
  test_entry_t                tests[$];

  always #5 clk = ~clk;  // 10 ns period

  l1d_cache u_l1d_cache (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .core_resp (core_resp),
    .mem_req   (mem_req),
    .mem_resp  (mem_resp)
  );

  mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .rand_waits  (rand_waits),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp),
    .read_count  (read_count),
    .write_count (write_count)
  );

  // ====================================================================
  // error reporting
  // ====================================================================
  task automatic stop_on_error();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    $display("FAIL %s %s expected %08h actual %08h", name, what, exp, act);
    stop_on_error();
  endtask

  task automatic report_text(string msg);
    $display("ERROR %s", msg);
    stop_on_error();
  endtask

  // expected address of the next refill read
  function automatic logic [31:0] fill_address();
    return line_base + 32'(4 * (read_count - reads_at_start));
  endfunction

  // memory port checks at every completed transfer
  always @(posedge clk) begin
    if (!rst && mem_req.req && !mem_resp.wait_n) begin
      assert (mem_req.addr < 32'h1000)
        else report_text($sformatf("%s sent memory address %08h past the 4 KiB model",
                                   cur_name, mem_req.addr));
      if (!mem_req.write) begin
        // refill reads walk the line word by word from offset 0
        assert (mem_req.addr == fill_address())
          else report_value(cur_name, "refill address", fill_address(), mem_req.addr);
        assert (mem_req.size == mem_access_pkg::size_word)
          else report_value(cur_name, "refill size", 32'(mem_access_pkg::size_word),
                            32'(mem_req.size));
      end else begin
        // write-through carries the core fields unchanged
        assert (mem_req.addr == cur_test.addr)
          else report_value(cur_name, "write address", cur_test.addr, mem_req.addr);
        assert (mem_req.wdata == cur_test.wdata)
          else report_value(cur_name, "write data", cur_test.wdata, mem_req.wdata);
        assert (mem_req.size == cur_test.size)
          else report_value(cur_name, "write size", 32'(cur_test.size), 32'(mem_req.size));
      end
    end
  end

  // ====================================================================
  // test data and sequencing
  // ====================================================================
  task automatic load_tests();
    int          fd;
    int          n;
    string       text;
    test_entry_t t;
    logic [7:0]  op;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [31:0] exp_reads;
    fd = $fopen(data_path, "r");
    assert (fd != 0) else report_text({"cannot open ", data_path});
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() < 2 || text.getc(0) == "#") continue;  // blank or column note
      n = $sscanf(text, "%c %h %h %h %h %d", op, size, addr, wdata, exp_rdata, exp_reads);
      assert (n == 6) else report_text({"malformed test data line: ", text});
      t = '{op: op, size: size, addr: addr, wdata: wdata,
            exp_rdata: exp_rdata, exp_reads: exp_reads};
      tests.push_back(t);
    end
    $fclose(fd);
    assert (tests.size() > 0) else report_text("test data file holds no accesses");
  endtask

  // reset for 5 cycles, req and ack low through it and the first idle cycle
  task automatic apply_reset();
    rst <= 1'b1;
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      assert (!mem_req.req) else report_value("reset", "mem req", 32'd0, 32'(mem_req.req));
      assert (!core_resp.ack) else report_value("reset", "ack", 32'd0, 32'(core_resp.ack));
    end
    rst <= 1'b0;
    @(posedge clk);  // end of the first idle cycle
    assert (!mem_req.req) else report_value("first_idle", "mem req", 32'd0, 32'(mem_req.req));
    assert (!core_resp.ack) else report_value("first_idle", "ack", 32'd0, 32'(core_resp.ack));
  endtask

  task automatic do_access(string name, test_entry_t t);
    int          cycles;
    int unsigned writes_at_start;
    @(posedge clk);
    core_req <= '{valid: 1'b1, write: (t.op == "W"), addr: t.addr, wdata: t.wdata,
                  size: mem_access_pkg::access_size_e'(t.size)};
    cur_test        = t;
    cur_name        = name;
    reads_at_start  = read_count;
    writes_at_start = write_count;
    line_base       = {t.addr[31:4], 4'h0};
    cycles          = 0;
    do begin
      @(posedge clk);
      cycles++;
      assert (cycles <= timeout_cycles) else report_text({name, " got no ack before timeout"});
    end while (!core_resp.ack);
    core_req.valid <= 1'b0;
    // sampled in the ack cycle itself
    assert (core_resp.rdata == t.exp_rdata)
      else report_value(name, "rdata", t.exp_rdata, core_resp.rdata);
    assert (read_count - reads_at_start == t.exp_reads)
      else report_value(name, "memory reads", t.exp_reads, read_count - reads_at_start);
    if (t.op == "W") begin
      assert (write_count - writes_at_start == 1)
        else report_value(name, "memory writes", 32'd1, write_count - writes_at_start);
    end else if (t.exp_reads == 0) begin
      // hit: drive edge, sample edge, lookup, then ack
      assert (cycles == 3) else report_value(name, "hit latency", 32'd3, 32'(cycles));
    end
  endtask

  initial begin
    void'($urandom(32'he378_9c65));
    rst        = 1'b1;
    rand_waits = 1'b0;
    core_req   = '0;
    line_base  = '0;
    cur_test   = '0;
    cur_name   = "reset";
    load_tests();
    for (int pass = 0; pass < 2; pass++) begin
      rand_waits <= (pass == 1);
      apply_reset();
      foreach (tests[i]) do_access($sformatf("pass%0d_access%0d", pass, i), tests[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* testbench/mem_model.sv */
/* behavioral word memory for the cache testbench, 4 KiB deep, address bits above 11 ignored.
   reset restores the fill pattern; rand_waits adds 0 to 2 wait cycles per transfer. */
module mem_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rand_waits,
  input  mem_access_pkg::mem_req_t  mem_req,
  output mem_access_pkg::mem_resp_t mem_resp,
  output int unsigned               read_count,   // completed reads
  output int unsigned               write_count   // completed writes
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth = 1024;

  logic [31:0] mem [depth];
  logic [1:0]  stall_cnt;  // wait cycles left for the current transfer
  logic [9:0]  widx;

  assign widx     = mem_req.addr[11:2];
  assign mem_resp = '{wait_n: (stall_cnt != 2'd0), rdata: mem[widx]};

  // bytes carried by one transfer
  function automatic int size_bytes(mem_access_pkg::access_size_e size);
    case (size)
      mem_access_pkg::size_byte, mem_access_pkg::size_byte_u: return 1;
      mem_access_pkg::size_half, mem_access_pkg::size_half_u: return 2;
      default: return 4;
    endcase
  endfunction

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) mem[i] <= 32'(i) ^ 32'h5a5a_0000;  // word addr xor tag
      stall_cnt   <= 2'd0;
      read_count  <= 0;
      write_count <= 0;
    end else if (mem_req.req) begin
      if (stall_cnt != 2'd0) begin
        stall_cnt <= stall_cnt - 2'd1;  // still holding the transfer
      end else begin
        if (mem_req.write) begin
          for (int b = 0; b < 4; b++) begin
            if (b < size_bytes(mem_req.size))
              mem[widx][8*(mem_req.addr[1:0] + 2'(b)) +: 8] <= mem_req.wdata[8*b +: 8];
          end
          write_count <= write_count + 1;
        end else begin
          read_count <= read_count + 1;
        end
        stall_cnt <= rand_waits ? 2'($urandom % 3) : 2'd0;  // waits for the next transfer
      end
    end
  end

endmodule

/* hw/l1d_cache.sv */
/* direct-mapped L1 data cache, 64 x 16 byte lines, write-through, no write allocate.
   one outstanding core access; memory transfers are single words. */
module l1d_cache (
  input  logic                       clk,
  input  logic                       rst,
  input  mem_access_pkg::core_req_t  core_req,
  output mem_access_pkg::core_resp_t core_resp,
  output mem_access_pkg::mem_req_t   mem_req,
  input  mem_access_pkg::mem_resp_t  mem_resp
);

  cache_geom_pkg::cache_addr_u req_addr;
  cache_geom_pkg::line_t       line;
  logic                        hit;
  logic                        ack;
  logic                        store_en;
  logic                        refill_en;
  logic [1:0]                  refill_word;
  logic                        set_valid;
  logic [31:0]                 load_rdata;

  assign req_addr.raw = core_req.addr;

  // ====================================================================
  // control and arrays
  // ====================================================================
  l1d_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .core_req    (core_req),
    .hit         (hit),
    .mem_resp    (mem_resp),
    .mem_req     (mem_req),
    .ack         (ack),
    .store_en    (store_en),
    .refill_en   (refill_en),
    .refill_word (refill_word),
    .set_valid   (set_valid)
  );

  tag_valid_store u_tags (
    .clk       (clk),
    .rst       (rst),
    .addr      (req_addr),
    .set_valid (set_valid),
    .hit       (hit)
  );

  line_data_store u_data (
    .clk         (clk),
    .addr        (req_addr),
    .size        (core_req.size),
    .wdata       (core_req.wdata),
    .store_en    (store_en),
    .refill_en   (refill_en),
    .refill_word (refill_word),
    .refill_data (mem_resp.rdata),  // straight from the memory bus
    .line        (line)
  );

  load_align u_align (
    .line  (line),
    .addr  (req_addr),
    .size  (core_req.size),
    .rdata (load_rdata)
  );

  // read data only in the ack cycle of a load
  assign core_resp = '{ack: ack, rdata: (ack && !core_req.write) ? load_rdata : 32'd0};

endmodule

/* hw/load_align.sv */
/* load data path, purely combinational.
   misaligned half or word loads return zero. */
module load_align (
  input  cache_geom_pkg::line_t        line,
  input  cache_geom_pkg::cache_addr_u  addr,
  input  mem_access_pkg::access_size_e size,
  output logic [31:0]                  rdata
);

  logic [31:0] word;
  logic [7:0]  b;
  logic [15:0] h;
  logic [1:0]  off;

  assign off  = addr.fields.byte_off;
  assign word = line[32*addr.fields.word +: 32];  // word select
  assign b    = word[8*off +: 8];
  assign h    = off[1] ? word[31:16] : word[15:0];

  always_comb begin
    rdata = 32'd0;
    case (size)
      mem_access_pkg::size_byte:   rdata = {{24{b[7]}}, b};  // sign extend
      mem_access_pkg::size_byte_u: rdata = {24'd0, b};
      mem_access_pkg::size_half: begin
        if (!off[0]) rdata = {{16{h[15]}}, h};
      end
      mem_access_pkg::size_half_u: begin
        if (!off[0]) rdata = {16'd0, h};
      end
      mem_access_pkg::size_word: begin
        if (off == 2'b00) rdata = word;
      end
      default: rdata = 32'd0;  // unused size codes
    endcase
  end

endmodule

/* hw/line_data_store.sv */
/* line data registers, asynchronous read of the addressed line.
   misaligned stores get no byte enables and leave the line unchanged. */
module line_data_store (
  input  logic                          clk,
  input  cache_geom_pkg::cache_addr_u   addr,
  input  mem_access_pkg::access_size_e  size,
  input  logic [31:0]                   wdata,
  input  logic                          store_en,
  input  logic                          refill_en,
  input  logic [1:0]                    refill_word,
  input  logic [31:0]                   refill_data,
  output cache_geom_pkg::line_t         line
);

  cache_geom_pkg::line_t    data_q [cache_geom_pkg::line_count];
  cache_geom_pkg::line_be_t line_be;
  cache_geom_pkg::line_t    merged;
  logic [3:0]               word_be;
  logic [31:0]              word_data;
  logic [1:0]               off;

  assign off  = addr.fields.byte_off;
  assign line = data_q[addr.fields.index];

  // ====================================================================
  // byte enables and lane placement
  // ====================================================================
  always_comb begin
    word_be   = 4'b0000;
    word_data = wdata;
    case (size)
      mem_access_pkg::size_byte, mem_access_pkg::size_byte_u: begin
        word_be   = 4'b0001 << off;
        word_data = {4{wdata[7:0]}};  // low byte on every lane
      end
      mem_access_pkg::size_half, mem_access_pkg::size_half_u: begin
        if (!off[0]) word_be = 4'b0011 << off;
        word_data = {2{wdata[15:0]}};
      end
      mem_access_pkg::size_word: begin
        if (off == 2'b00) word_be = 4'b1111;
      end
      default: word_be = 4'b0000;
    endcase
    line_be = cache_geom_pkg::line_be_t'(word_be) << {addr.fields.word, 2'b00};
  end

  // merge enabled bytes over the current line
  always_comb begin
    for (int i = 0; i < cache_geom_pkg::line_bytes; i++) begin
      merged[8*i +: 8] = line_be[i] ? word_data[8*(i%4) +: 8] : line[8*i +: 8];
    end
  end

  // ====================================================================
  // write port
  // ====================================================================
  always_ff @(posedge clk) begin
    if (store_en) begin
      data_q[addr.fields.index] <= merged;
    end else if (refill_en) begin
      data_q[addr.fields.index][{refill_word, 5'b00000} +: 32] <= refill_data;  // one word
    end
  end

endmodule

/* hw/tag_valid_store.sv */
/* tag array plus valid bits, asynchronous read.
   only refill writes a tag, so a valid line always matches memory. */
module tag_valid_store (
  input  logic                        clk,
  input  logic                        rst,
  input  cache_geom_pkg::cache_addr_u addr,
  input  logic                        set_valid,
  output logic                        hit
);

  logic [cache_geom_pkg::tag_bits-1:0]   tag_q [cache_geom_pkg::line_count];
  logic [cache_geom_pkg::line_count-1:0] valid_q;
  logic [cache_geom_pkg::index_bits-1:0] idx;

  assign idx = addr.fields.index;

  // valid bits, cleared on reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else if (set_valid) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tags are written once per refill
  always_ff @(posedge clk) begin
    if (set_valid) tag_q[idx] <= addr.fields.tag;
  end

  // combinational compare on the current index
  assign hit = valid_q[idx] && (tag_q[idx] == addr.fields.tag);

endmodule

/* hw/l1d_ctrl.sv */
/* access FSM for the write-through, no-allocate data cache.
   core fields must stay stable from valid until ack; one access in flight. */
module l1d_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  mem_access_pkg::core_req_t core_req,
  input  logic                      hit,
  input  mem_access_pkg::mem_resp_t mem_resp,
  output mem_access_pkg::mem_req_t  mem_req,
  output logic                      ack,
  output logic                      store_en,
  output logic                      refill_en,
  output logic [1:0]                refill_word,
  output logic                      set_valid
);

  typedef enum logic [2:0] {
    idle,
    lookup,       // tag compare, store merge on write hit
    write_mem,    // write-through transfer
    refill_req,   // one word read per transfer
    done          // ack cycle
  } state_e;

  state_e                    state, state_nxt;
  logic [1:0]                fill_cnt;   // word being refilled
  cache_geom_pkg::cache_addr_u fill_addr;
  logic                      mem_go;     // transfer completes this cycle

  assign mem_go      = ~mem_resp.wait_n;
  assign ack         = (state == done);
  assign refill_word = fill_cnt;

  // ====================================================================
  // state and refill counter
  // ====================================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= idle;
      fill_cnt <= 2'd0;
    end else begin
      state <= state_nxt;
      if (refill_en) fill_cnt <= fill_cnt + 2'd1;  // wraps to 0 after word 3
    end
  end

  // ====================================================================
  // next state and strobes
  // ====================================================================
  always_comb begin
    state_nxt = state;
    store_en  = 1'b0;
    refill_en = 1'b0;
    set_valid = 1'b0;
    case (state)
      idle: begin
        if (core_req.valid) state_nxt = lookup;
      end
      lookup: begin
        if (core_req.write) begin
          store_en  = hit;  // merge only into a resident line
          state_nxt = write_mem;
        end else if (hit) begin
          state_nxt = done;
        end else begin
          state_nxt = refill_req;
        end
      end
      write_mem: begin
        if (mem_go) state_nxt = done;
      end
      refill_req: begin
        if (mem_go) begin
          refill_en = 1'b1;
          if (fill_cnt == 2'd3) begin
            set_valid = 1'b1;    // line complete
            state_nxt = lookup;  // replay, now a hit
          end
        end
      end
      done:    state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  // ====================================================================
  // memory port
  // ====================================================================
  always_comb begin
    fill_addr.raw             = core_req.addr;
    fill_addr.fields.word     = fill_cnt;  // word offset 0..3 of the line
    fill_addr.fields.byte_off = 2'b00;

    // default: write-through fields straight from the core
    mem_req.req   = (state == write_mem);
    mem_req.write = core_req.write;
    mem_req.addr  = core_req.addr;
    mem_req.wdata = core_req.wdata;
    mem_req.size  = core_req.size;
    if (state == refill_req) begin
      mem_req.req   = 1'b1;
      mem_req.write = 1'b0;
      mem_req.addr  = fill_addr.raw;
      mem_req.size  = mem_access_pkg::size_word;  // refill is always whole words
    end
  end

endmodule

/* hw/mem_access_pkg.sv */
/* request and response words for the core port and the memory port.
   size codes follow the load/store funct3 style, bit 2 set means unsigned. */
package mem_access_pkg;

  // ====================================================================
  // access size
  // ====================================================================
  typedef enum logic [2:0] {
    size_byte   = 3'b000,
    size_half   = 3'b001,
    size_word   = 3'b010,
    size_byte_u = 3'b100,
    size_half_u = 3'b101
  } access_size_e;

  // core -> cache, held until ack
  typedef struct packed {
    logic         valid;
    logic         write;  // 1 = store
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_e size;
  } core_req_t;

  // cache -> core
  typedef struct packed {
    logic        ack;    // one cycle per access
    logic [31:0] rdata;  // zero on writes
  } core_resp_t;

  // cache -> memory, held until wait is low
  typedef struct packed {
    logic         req;
    logic         write;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_e size;
  } mem_req_t;

  // memory -> cache
  typedef struct packed {
    logic        wait_n;  // memory wait, high holds the transfer
    logic [31:0] rdata;   // valid in the cycle wait drops
  } mem_resp_t;

endpackage

/* hw/cache_geom_pkg.sv */
/* geometry of the direct-mapped data cache: 64 lines of 16 bytes, 32-bit addresses.
   the address union is the only place the field layout is defined. */
package cache_geom_pkg;

  // ====================================================================
  // line geometry
  // ====================================================================
  localparam int line_count     = 64;
  localparam int index_bits     = 6;
  localparam int tag_bits       = 22;  // addr[31:10]
  localparam int words_per_line = 4;
  localparam int line_bytes     = 16;

  // address split, msb first
  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
    logic [1:0]            word;      // word within the line
    logic [1:0]            byte_off;  // byte within the word
  } cache_addr_fields_t;

  // one address word, seen either raw or split into fields
  typedef union packed {
    logic [31:0]        raw;
    cache_addr_fields_t fields;
  } cache_addr_u;

  typedef logic [32*words_per_line-1:0] line_t;  // word 0 in the low bits
  typedef logic [line_bytes-1:0]        line_be_t;  // one bit per byte, high = write

endpackage
